/* rtl/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // fixed family code in the top nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    localparam int ADDR_W    = 11;     // 3 block bits + 8 word bits
    localparam int MEM_DEPTH = 2048;
    localparam int BYTE_W    = 8;

    // controller phase within one bus transaction
    typedef enum logic [2:0]
    {
        IDLE,       // no transaction open
        CTRL,       // waiting for the control byte
        ADDR,       // waiting for the word address
        WDATA,      // waiting for the byte to store
        RDATA,      // sending the byte at the address
        IGNORE      // not addressed, or transfer finished
    } xfer_state_t;

endpackage

`default_nettype wire

/* rtl/bus_sampler.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_sampler #(
    parameter int SYNC_STAGES = 2
) (
    input  logic sda,
    input  logic rst_n,
    input  logic bus_scl,
    input  logic bus_din,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_seen,
    output logic stop_seen,
    output logic din_s
);

    logic [SYNC_STAGES-1:0] scl_sync;
    logic [SYNC_STAGES-1:0] din_sync;
    logic                   scl_now;
    logic                   din_now;
    logic                   scl_d;

    assign scl_now = scl_sync[SYNC_STAGES-1];
    assign din_now = din_sync[SYNC_STAGES-1];

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            scl_sync   <= '1;           // idle bus is high
            din_sync   <= '1;
            scl_d      <= 1'b1;
            din_s      <= 1'b1;
            scl_rise   <= 1'b0;
            scl_fall   <= 1'b0;
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
        end
        else
        begin
            scl_sync   <= {scl_sync[SYNC_STAGES-2:0], bus_scl};
            din_sync   <= {din_sync[SYNC_STAGES-2:0], bus_din};
            scl_d      <= scl_now;
            din_s      <= din_now;      // also the delayed copy for edge compare
            scl_rise   <= scl_now & ~scl_d;
            scl_fall   <= ~scl_now & scl_d;
            start_seen <= scl_now & scl_d & din_s & ~din_now;
            stop_seen  <= scl_now & scl_d & ~din_s & din_now;
        end
    end

    // a single data edge cannot be both conditions
    a_start_stop_excl : assert property (
        @(posedge sda) disable iff (!rst_n)
        !(start_seen && stop_seen)
    ) else $error("bus_sampler: start and stop flagged together");

endmodule

`default_nettype wire

/* rtl/bit_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module bit_shifter (
    input  logic                          sda,
    input  logic                          rst_n,
    input  logic                          scl_rise,
    input  logic                          scl_fall,
    input  logic                          start_seen,
    input  logic                          stop_seen,
    input  logic                          din_s,
    input  logic                          ack_en,
    input  logic                          tx_load,
    input  logic [eeprom_pkg::BYTE_W-1:0] tx_byte,
    output logic [eeprom_pkg::BYTE_W-1:0] rx_byte,
    output logic                          byte_done,
    output logic                          ack_slot,
    output logic                          bus_doe
);

    import eeprom_pkg::*;

    logic [3:0]        bit_cnt;         // 0..7 data bits, 8 = ninth bit
    logic              active;
    logic              tx_mode;
    logic              tx_pend;         // read byte loaded, waits for ack slot end
    logic              tx_shift;
    logic [BYTE_W-2:0] rx_sr;
    logic [BYTE_W-1:0] tx_sr;

    // the eighth bit is merged in directly so rx_byte is whole with byte_done
    // in tx mode the ninth rise puts the master ack on bit 0
    assign rx_byte   = {rx_sr, din_s};
    assign byte_done = active && scl_rise && (bit_cnt == 4'd7);

    // next bit goes out at end of ack slot, then on each data-bit fall
    assign tx_shift = active && scl_fall &&
                      (ack_slot ? tx_pend : (tx_mode && (bit_cnt != 4'd8)));

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            bit_cnt  <= '0;
            active   <= 1'b0;
            tx_mode  <= 1'b0;
            tx_pend  <= 1'b0;
            ack_slot <= 1'b0;
            bus_doe  <= 1'b0;
        end
        else if (start_seen || stop_seen)
        begin
            bit_cnt  <= '0;
            active   <= start_seen;
            tx_mode  <= 1'b0;
            tx_pend  <= 1'b0;
            ack_slot <= 1'b0;
            bus_doe  <= 1'b0;           // release the line
        end
        else
        begin
            if (tx_load)
            begin
                tx_pend <= 1'b1;
            end
            if (active && scl_rise)
            begin
                if (bit_cnt == 4'd8)
                begin
                    bit_cnt <= '0;
                    tx_mode <= 1'b0;    // single byte read only
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            if (active && scl_fall)
            begin
                if (ack_slot)
                begin
                    ack_slot <= 1'b0;
                    bus_doe  <= 1'b0;
                    if (tx_pend)
                    begin
                        tx_pend <= 1'b0;
                        tx_mode <= 1'b1;
                    end
                end
                else if (bit_cnt == 4'd8)
                begin
                    ack_slot <= 1'b1;
                    bus_doe  <= ack_en & ~tx_mode;  // master acks a read byte
                end
                if (tx_shift)
                begin
                    bus_doe <= ~tx_sr[BYTE_W-1];    // pull low for a 0
                end
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (active && scl_rise && (bit_cnt != 4'd8))
        begin
            rx_sr <= rx_byte[BYTE_W-2:0];
        end
        if (tx_load)
        begin
            tx_sr <= tx_byte;
        end
        else if (tx_shift)
        begin
            tx_sr <= {tx_sr[BYTE_W-2:0], 1'b0};
        end
    end

    a_stop_releases : assert property (
        @(posedge sda) disable iff (!rst_n)
        stop_seen |=> !bus_doe
    ) else $error("bit_shifter: line still driven after stop");

endmodule

`default_nettype wire

/* rtl/transfer_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module transfer_ctrl (
    input  logic                          sda,
    input  logic                          rst_n,
    input  logic                          start_seen,
    input  logic                          stop_seen,
    input  logic                          byte_done,
    input  logic [eeprom_pkg::BYTE_W-1:0] rx_byte,
    output logic                          ack_en,
    output logic                          tx_load,
    output logic [eeprom_pkg::BYTE_W-1:0] tx_byte,
    output logic                          wr_en,
    output logic [eeprom_pkg::ADDR_W-1:0] addr,
    output logic [eeprom_pkg::BYTE_W-1:0] wr_data,
    output logic [eeprom_pkg::ADDR_W-1:0] rd_addr,
    input  logic [eeprom_pkg::BYTE_W-1:0] rd_data
);

    import eeprom_pkg::*;

    xfer_state_t              state;
    logic [ADDR_W-BYTE_W-1:0] blk;
    logic [BYTE_W-1:0]        addr_lo;
    logic                     load_pend;
    logic                     dev_match;
    logic                     ctrl_ok;

    assign dev_match = (rx_byte[BYTE_W-1:BYTE_W-4] == DEVICE_CODE);
    assign ctrl_ok   = byte_done && (state == CTRL) && dev_match;

    assign addr    = {blk, addr_lo};
    assign rd_addr = addr;
    assign tx_byte = rd_data;           // valid once tx_load rises

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            state     <= IDLE;
            ack_en    <= 1'b0;
            wr_en     <= 1'b0;
            tx_load   <= 1'b0;
            load_pend <= 1'b0;
        end
        else
        begin
            wr_en     <= 1'b0;
            load_pend <= 1'b0;
            tx_load   <= load_pend;     // rd_addr settles, then rd_data
            if (stop_seen)
            begin
                state  <= IDLE;
                ack_en <= 1'b0;
            end
            else if (start_seen)
            begin
                state  <= CTRL;         // repeated start keeps the address
                ack_en <= 1'b0;
            end
            else if (byte_done)
            begin
                ack_en <= 1'b0;
                case (state)
                    CTRL:
                    begin
                        if (dev_match)
                        begin
                            ack_en <= 1'b1;
                            if (rx_byte[0])
                            begin
                                state     <= RDATA;
                                load_pend <= 1'b1;
                            end
                            else
                            begin
                                state <= ADDR;
                            end
                        end
                        else
                        begin
                            state <= IGNORE;
                        end
                    end
                    ADDR:
                    begin
                        ack_en <= 1'b1;
                        state  <= WDATA;
                    end
                    WDATA:
                    begin
                        ack_en <= 1'b1;
                        wr_en  <= 1'b1;
                        state  <= IGNORE;   // no page writes
                    end
                    default:
                    begin
                        state <= IGNORE;    // master acks the read byte itself
                    end
                endcase
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (ctrl_ok)
        begin
            blk <= rx_byte[ADDR_W-BYTE_W:1];    // block select bits
        end
        if (byte_done && (state == ADDR))
        begin
            addr_lo <= rx_byte;
        end
        if (byte_done && (state == WDATA))
        begin
            wr_data <= rx_byte;
        end
    end

    a_write_in_wdata : assert property (
        @(posedge sda) disable iff (!rst_n)
        wr_en |-> ($past(state) == WDATA)
    ) else $error("transfer_ctrl: write outside the data phase");

endmodule

`default_nettype wire

/* rtl/byte_store.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_store (
    input  logic                          sda,
    input  logic                          wr_en,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::BYTE_W-1:0] wr_data,
    input  logic [eeprom_pkg::ADDR_W-1:0] rd_addr,
    output logic [eeprom_pkg::BYTE_W-1:0] rd_data
);

    import eeprom_pkg::*;

    logic [BYTE_W-1:0] mem [MEM_DEPTH];

    always_ff @(posedge sda)
    begin
        if (wr_en)
        begin
            mem[addr] <= wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge sda)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* rtl/serial_eeprom.sv */
`timescale 1ns/100ps
`default_nettype none

module serial_eeprom (
    input  logic sda,
    input  logic rst_n,
    input  logic bus_scl,
    input  logic bus_din,
    output logic bus_doe
);

    import eeprom_pkg::*;

    logic              scl_rise;
    logic              scl_fall;
    logic              start_seen;
    logic              stop_seen;
    logic              din_s;
    logic [BYTE_W-1:0] rx_byte;
    logic              byte_done;
    logic              ack_en;
    logic              tx_load;
    logic [BYTE_W-1:0] tx_byte;
    logic              wr_en;
    logic [ADDR_W-1:0] addr;
    logic [BYTE_W-1:0] wr_data;
    logic [ADDR_W-1:0] rd_addr;
    logic [BYTE_W-1:0] rd_data;

    bus_sampler #(
        .SYNC_STAGES (2)
    ) u_bus_sampler (
        .sda        (sda),
        .rst_n      (rst_n),
        .bus_scl    (bus_scl),
        .bus_din    (bus_din),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .din_s      (din_s)
    );

    bit_shifter u_bit_shifter (
        .sda        (sda),
        .rst_n      (rst_n),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .din_s      (din_s),
        .ack_en     (ack_en),
        .tx_load    (tx_load),
        .tx_byte    (tx_byte),
        .rx_byte    (rx_byte),
        .byte_done  (byte_done),
        .ack_slot   (),
        .bus_doe    (bus_doe)
    );

    transfer_ctrl u_transfer_ctrl (
        .sda        (sda),
        .rst_n      (rst_n),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .byte_done  (byte_done),
        .rx_byte    (rx_byte),
        .ack_en     (ack_en),
        .tx_load    (tx_load),
        .tx_byte    (tx_byte),
        .wr_en      (wr_en),
        .addr       (addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    byte_store u_byte_store (
        .sda     (sda),
        .wr_en   (wr_en),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 2,     // 4 ns period
    parameter int RESET_CYCLES = 5
) (
    output logic sda,
    output logic rst_n
);

    initial
    begin
        sda = 1'b0;
        forever
        begin
            #(HALF_PERIOD) sda = ~sda;
        end
    end

    // reset lets go on a falling edge, like every other input
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sda);
        @(negedge sda);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/tb_serial_eeprom.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_serial_eeprom;

    localparam int PHASE   = 16;            // sda cycles per bus clock phase
    localparam int HALF    = PHASE / 2;
    localparam int N_RAND  = 8;
    localparam int RST_MAX = 50;

    logic        sda;
    logic        rst_n;
    logic        bus_scl;
    logic        m_sda;                     // master side of the open-drain line
    logic        bus_din;
    logic        bus_doe;
    logic        before_bus;
    logic        not_addressed;
    logic        timed_out;
    int          errors;
    int          checks;
    integer      seed;
    logic [7:0]  ref_mem [2048];
    logic [10:0] addr_list [N_RAND];

    // wired line, an unknown enable before reset counts as released
    assign bus_din = m_sda && (bus_doe !== 1'b1);

    tb_clock u_clock (
        .sda   (sda),
        .rst_n (rst_n)
    );

    serial_eeprom u_dut (
        .sda     (sda),
        .rst_n   (rst_n),
        .bus_scl (bus_scl),
        .bus_din (bus_din),
        .bus_doe (bus_doe)
    );

    a_idle_quiet : assert property (
        @(posedge sda) disable iff (!rst_n)
        before_bus |-> !bus_doe
    ) else
    begin
        errors = errors + 1;
        $display("FAILED idle_quiet: expected bus_doe 0 actual %0b", bus_doe);
    end

    // slave must stay off the line once the device code was wrong
    a_ignored_quiet : assert property (
        @(posedge sda) disable iff (!rst_n)
        not_addressed |-> !bus_doe
    ) else
    begin
        errors = errors + 1;
        $display("FAILED ignored_quiet: expected bus_doe 0 actual %0b", bus_doe);
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge sda);
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks = checks + 1;
        assert (act === exp)
        else
        begin
            errors = errors + 1;
            $display("FAILED %s: expected %02h actual %02h", name, exp, act);
        end
    endtask

    function automatic logic [7:0] ctrl_byte(input logic [2:0] blk, input logic rd);
        return {4'b1010, blk, rd};
    endfunction

    task automatic issue_start();
        not_addressed = 1'b0;
        m_sda = 1'b1;
        wait_cycles(HALF);
        bus_scl = 1'b1;
        wait_cycles(PHASE);
        m_sda = 1'b0;                       // data falls with clock high
        wait_cycles(PHASE);
        bus_scl = 1'b0;
        wait_cycles(HALF);
    endtask

    task automatic issue_stop();
        m_sda = 1'b0;
        wait_cycles(HALF);
        bus_scl = 1'b1;
        wait_cycles(PHASE);
        m_sda = 1'b1;                       // data rises with clock high
        wait_cycles(PHASE);
    endtask

    task automatic send_bit(input logic b);
        m_sda = b;
        wait_cycles(HALF);
        bus_scl = 1'b1;
        wait_cycles(PHASE);
        bus_scl = 1'b0;
        wait_cycles(HALF);
    endtask

    task automatic recv_bit(output logic b);
        m_sda = 1'b1;
        wait_cycles(HALF);
        bus_scl = 1'b1;
        wait_cycles(HALF);
        b = bus_din;                        // middle of the high phase
        wait_cycles(HALF);
        bus_scl = 1'b0;
        wait_cycles(HALF);
    endtask

    task automatic check_ack(input string name, input logic exp);
        int   cnt;
        logic acked;
        m_sda = 1'b1;
        wait_cycles(HALF);
        bus_scl = 1'b1;
        cnt = 0;
        while (bus_din && (cnt < PHASE))
        begin
            @(negedge sda);
            cnt = cnt + 1;
        end
        acked = !bus_din;
        wait_cycles(PHASE - cnt);
        bus_scl = 1'b0;
        wait_cycles(HALF);
        checks = checks + 1;
        assert (acked === exp)
        else
        begin
            errors = errors + 1;
            $display("FAILED %s: expected ack %0b actual ack %0b", name, exp, acked);
        end
    endtask

    task automatic send_byte(input string name, input logic [7:0] b, input logic exp_ack);
        for (int i = 7; i >= 0; i--)
        begin
            send_bit(b[i]);
        end
        check_ack(name, exp_ack);
    endtask

    task automatic recv_byte(output logic [7:0] b);
        logic [7:0] v;
        logic       bit_v;
        for (int i = 7; i >= 0; i--)
        begin
            recv_bit(bit_v);
            v[i] = bit_v;
        end
        send_bit(1'b1);                     // not-acknowledge ends the read
        b = v;
    endtask

    task automatic write_mem(input logic [10:0] a, input logic [7:0] d);
        issue_start();
        send_byte("wr_ctrl", ctrl_byte(a[10:8], 1'b0), 1'b1);
        send_byte("wr_addr", a[7:0], 1'b1);
        send_byte("wr_data", d, 1'b1);
        issue_stop();
        ref_mem[a] = d;
    endtask

    task automatic read_mem(input logic [10:0] a, output logic [7:0] d);
        issue_start();
        send_byte("rd_ctrl_w", ctrl_byte(a[10:8], 1'b0), 1'b1);
        send_byte("rd_addr", a[7:0], 1'b1);
        issue_start();                      // repeated start
        send_byte("rd_ctrl_r", ctrl_byte(a[10:8], 1'b1), 1'b1);
        recv_byte(d);
        issue_stop();
    endtask

    task automatic run_tests();
        logic [31:0] rnd;
        logic [7:0]  got;
        logic [10:0] a;
        wait_cycles(40);
        before_bus = 1'b0;

        issue_start();
        send_byte("ack_good_ctrl", ctrl_byte(3'd0, 1'b0), 1'b1);
        send_byte("ack_good_addr", 8'h00, 1'b1);
        issue_stop();
        issue_start();
        not_addressed = 1'b1;
        send_byte("nack_bad_ctrl", 8'hB0, 1'b0);
        send_byte("nack_after_bad_0", 8'h5A, 1'b0);
        send_byte("nack_after_bad_1", 8'hC3, 1'b0);
        issue_stop();

        for (int i = 0; i < N_RAND; i++)
        begin
            rnd = $random(seed);
            addr_list[i] = rnd[10:0];
            write_mem(rnd[10:0], rnd[23:16]);
        end
        for (int i = 0; i < N_RAND; i++)
        begin
            read_mem(addr_list[i], got);
            compare_byte($sformatf("rand_rd_%0d", i), ref_mem[addr_list[i]], got);
        end

        // same word address under each block select
        rnd = $random(seed);
        for (int b = 0; b < 8; b++)
        begin
            write_mem({b[2:0], rnd[15:8]}, {rnd[4:0], b[2:0]});
        end
        for (int b = 0; b < 8; b++)
        begin
            read_mem({b[2:0], rnd[15:8]}, got);
            compare_byte($sformatf("blk_rd_%0d", b), {rnd[4:0], b[2:0]}, got);
        end

        a = addr_list[0];
        issue_start();
        send_byte("abort_ctrl", ctrl_byte(a[10:8], 1'b0), 1'b1);
        send_byte("abort_addr", a[7:0], 1'b1);
        issue_stop();                       // no data byte
        read_mem(a, got);
        compare_byte("abort_keep", ref_mem[a], got);
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if ((errors == 0) && !timed_out)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial
    begin
        int cnt;
        bus_scl       = 1'b1;
        m_sda         = 1'b1;
        before_bus    = 1'b1;
        not_addressed = 1'b0;
        timed_out     = 1'b0;
        errors        = 0;
        checks        = 0;
        seed          = 32'h80ad;
        cnt           = 0;
        while ((rst_n !== 1'b1) && (cnt < RST_MAX))
        begin
            @(negedge sda);
            cnt = cnt + 1;
        end
        if (rst_n === 1'b1)
        begin
            run_tests();
        end
        else
        begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* project.f */
rtl/eeprom_pkg.sv
rtl/bus_sampler.sv
rtl/bit_shifter.sv
rtl/transfer_ctrl.sv
rtl/byte_store.sv
rtl/serial_eeprom.sv
bench/tb_clock.sv
bench/tb_serial_eeprom.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_serial_eeprom
FILELIST := project.f
OBJ_DIR  := obj_dir
PASS_MSG := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
